// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath width in bits.
`define RV_XLEN 32

// architectural register count.
`define RV_NREGS 32

// unified memory, in 32-bit words.
`define RV_MEM_WORDS 256
`define RV_MEM_AW 8

`endif

// ==== source/rv_pkg.sv ====
package rv_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [6:0] {
		OPCODE_LUI      = 7'b0110111,
		OPCODE_AUIPC    = 7'b0010111,
		OPCODE_JAL      = 7'b1101111,
		OPCODE_JALR     = 7'b1100111,
		OPCODE_BRANCH   = 7'b1100011,
		OPCODE_LOAD     = 7'b0000011,
		OPCODE_STORE    = 7'b0100011,
		OPCODE_OP_IMM   = 7'b0010011,
		OPCODE_OP       = 7'b0110011,
		OPCODE_MISC_MEM = 7'b0001111
	} opcode_t;

	typedef enum logic [2:0] {
		FUNCT3_BRANCH_BEQ  = 3'b000,
		FUNCT3_BRANCH_BNE  = 3'b001,
		FUNCT3_BRANCH_BLT  = 3'b100,
		FUNCT3_BRANCH_BGE  = 3'b101,
		FUNCT3_BRANCH_BLTU = 3'b110,
		FUNCT3_BRANCH_BGEU = 3'b111
	} funct3_branch_t;

	// shared by loads and stores.
	typedef enum logic [2:0] {
		FUNCT3_MEM_B  = 3'b000,
		FUNCT3_MEM_H  = 3'b001,
		FUNCT3_MEM_W  = 3'b010,
		FUNCT3_MEM_BU = 3'b100,
		FUNCT3_MEM_HU = 3'b101
	} funct3_mem_t;

	// shared by op and op-imm.
	typedef enum logic [2:0] {
		FUNCT3_OP_ADD_SUB = 3'b000,
		FUNCT3_OP_SLL     = 3'b001,
		FUNCT3_OP_SLT     = 3'b010,
		FUNCT3_OP_SLTU    = 3'b011,
		FUNCT3_OP_XOR     = 3'b100,
		FUNCT3_OP_SR      = 3'b101,
		FUNCT3_OP_OR      = 3'b110,
		FUNCT3_OP_AND     = 3'b111
	} funct3_op_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control selects
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		ALU_OP_ADD,
		ALU_OP_SUB,
		ALU_OP_SLL,
		ALU_OP_SLT,
		ALU_OP_SLTU,
		ALU_OP_XOR,
		ALU_OP_SRL,
		ALU_OP_SRA,
		ALU_OP_OR,
		ALU_OP_AND,
		ALU_OP_IN2_PASSTHROUGH
	} alu_op_t;

	typedef enum logic [2:0] {
		COMPARE_OP_EQ,
		COMPARE_OP_NE,
		COMPARE_OP_LT,
		COMPARE_OP_GE,
		COMPARE_OP_LTU,
		COMPARE_OP_GEU
	} compare_op_t;

	typedef enum logic [1:0] {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT,
		NEXT_PC_SEL_COMPARE_OUT
	} next_pc_sel_t;

	typedef enum logic [1:0] {
		REGFILE_IN_SEL_ALU_OUT,
		REGFILE_IN_SEL_PC_4,
		REGFILE_IN_SEL_MEM_RD
	} regfile_in_sel_t;

	typedef enum logic {
		ALU_IN1_SEL_REG1,
		ALU_IN1_SEL_PC
	} alu_in1_sel_t;

	typedef enum logic [2:0] {
		ALU_IN2_SEL_REG2,
		ALU_IN2_SEL_U_IMM,
		ALU_IN2_SEL_J_IMM,
		ALU_IN2_SEL_I_IMM,
		ALU_IN2_SEL_B_IMM,
		ALU_IN2_SEL_S_IMM
	} alu_in2_sel_t;

	typedef enum logic [1:0] {
		MEM_SIZE_BYTE,
		MEM_SIZE_HALF,
		MEM_SIZE_WORD
	} mem_size_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction layouts
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcode_t opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcode_t opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			opcode_t opcode;
		} s;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			opcode_t opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0] rd;
			opcode_t opcode;
		} u;
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			opcode_t opcode;
		} j;
	} instruction_t;

endpackage

// ==== source/rv_ctrl_if.sv ====
interface rv_ctrl_if;
	import rv_pkg::*;

	// write strobes.
	logic pc_we;
	logic ir_we;
	logic regfile_we;
	logic mem_wr_en;

	// memory access shape.
	logic mem_addr_from_alu;
	mem_size_t mem_size;
	logic mem_signed;

	// datapath selects.
	next_pc_sel_t next_pc_sel;
	regfile_in_sel_t regfile_in_sel;
	alu_op_t alu_op;
	alu_in1_sel_t alu_in1_sel;
	alu_in2_sel_t alu_in2_sel;
	compare_op_t compare_op;

	modport control (
		output pc_we, ir_we, regfile_we, mem_wr_en,
		output mem_addr_from_alu, mem_size, mem_signed,
		output next_pc_sel, regfile_in_sel, alu_op,
		output alu_in1_sel, alu_in2_sel, compare_op
	);

	modport datapath (
		input pc_we, ir_we, regfile_we, mem_wr_en,
		input mem_addr_from_alu, mem_size, mem_signed,
		input next_pc_sel, regfile_in_sel, alu_op,
		input alu_in1_sel, alu_in2_sel, compare_op
	);
endinterface

// ==== source/rv_control.sv ====
module rv_control (
	input logic clk_i,
	input logic reset_i,
	input logic misaligned_i,
	input rv_pkg::instruction_t ir_i,
	output logic halted_o,
	output logic retire_valid_o,
	rv_ctrl_if.control ctrl
);
	import rv_pkg::*;

	typedef enum logic [1:0] {
		RESET,
		FETCH,
		EXECUTE,
		ERROR
	} state_t;

	state_t state;
	state_t next_state;
	logic dec_regfile_we;
	logic dec_mem_wr_en;
	logic commit;

	// a misaligned access kills every write of the cycle.
	assign commit = (state == EXECUTE) && !misaligned_i;

	assign ctrl.ir_we = (state == FETCH);
	assign ctrl.pc_we = commit;
	assign ctrl.regfile_we = dec_regfile_we && commit;
	assign ctrl.mem_wr_en = dec_mem_wr_en && commit;

	assign retire_valid_o = commit;
	assign halted_o = (state == ERROR);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoder
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		dec_regfile_we = 1'b0;
		dec_mem_wr_en = 1'b0;
		ctrl.mem_addr_from_alu = 1'b0;
		ctrl.mem_size = MEM_SIZE_WORD;
		ctrl.mem_signed = 1'b0;
		ctrl.next_pc_sel = NEXT_PC_SEL_PC_4;

		// don't care unless overridden below.
		ctrl.regfile_in_sel = REGFILE_IN_SEL_ALU_OUT;
		ctrl.alu_op = ALU_OP_ADD;
		ctrl.alu_in1_sel = ALU_IN1_SEL_REG1;
		ctrl.alu_in2_sel = ALU_IN2_SEL_REG2;
		ctrl.compare_op = COMPARE_OP_EQ;

		if (state == EXECUTE) begin
			unique case (ir_i.r.opcode)
			OPCODE_LUI: begin
				dec_regfile_we = 1'b1;
				ctrl.alu_op = ALU_OP_IN2_PASSTHROUGH;
				ctrl.alu_in2_sel = ALU_IN2_SEL_U_IMM;
			end
			OPCODE_AUIPC: begin
				dec_regfile_we = 1'b1;
				ctrl.alu_in1_sel = ALU_IN1_SEL_PC;
				ctrl.alu_in2_sel = ALU_IN2_SEL_U_IMM;
			end
			OPCODE_JAL: begin
				dec_regfile_we = 1'b1;
				ctrl.regfile_in_sel = REGFILE_IN_SEL_PC_4;
				ctrl.next_pc_sel = NEXT_PC_SEL_ALU_OUT;
				ctrl.alu_in1_sel = ALU_IN1_SEL_PC;
				ctrl.alu_in2_sel = ALU_IN2_SEL_J_IMM;
			end
			OPCODE_JALR: begin
				dec_regfile_we = 1'b1;
				ctrl.regfile_in_sel = REGFILE_IN_SEL_PC_4;
				ctrl.next_pc_sel = NEXT_PC_SEL_ALU_OUT;
				ctrl.alu_in2_sel = ALU_IN2_SEL_I_IMM;
			end
			OPCODE_BRANCH: begin
				ctrl.next_pc_sel = NEXT_PC_SEL_COMPARE_OUT;
				ctrl.alu_in1_sel = ALU_IN1_SEL_PC;
				ctrl.alu_in2_sel = ALU_IN2_SEL_B_IMM;
				unique case (funct3_branch_t'(ir_i.b.funct3))
				FUNCT3_BRANCH_BNE:
					ctrl.compare_op = COMPARE_OP_NE;
				FUNCT3_BRANCH_BLT:
					ctrl.compare_op = COMPARE_OP_LT;
				FUNCT3_BRANCH_BGE:
					ctrl.compare_op = COMPARE_OP_GE;
				FUNCT3_BRANCH_BLTU:
					ctrl.compare_op = COMPARE_OP_LTU;
				FUNCT3_BRANCH_BGEU:
					ctrl.compare_op = COMPARE_OP_GEU;
				default:
					ctrl.compare_op = COMPARE_OP_EQ;
				endcase
			end
			OPCODE_LOAD, OPCODE_STORE: begin
				ctrl.mem_addr_from_alu = 1'b1;
				if (ir_i.r.opcode == OPCODE_LOAD) begin
					dec_regfile_we = 1'b1;
					ctrl.regfile_in_sel = REGFILE_IN_SEL_MEM_RD;
					ctrl.alu_in2_sel = ALU_IN2_SEL_I_IMM;
				end else begin
					dec_mem_wr_en = 1'b1;
					ctrl.alu_in2_sel = ALU_IN2_SEL_S_IMM;
				end
				unique case (funct3_mem_t'(ir_i.i.funct3))
				FUNCT3_MEM_B: begin
					ctrl.mem_size = MEM_SIZE_BYTE;
					ctrl.mem_signed = 1'b1;
				end
				FUNCT3_MEM_H: begin
					ctrl.mem_size = MEM_SIZE_HALF;
					ctrl.mem_signed = 1'b1;
				end
				FUNCT3_MEM_BU:
					ctrl.mem_size = MEM_SIZE_BYTE;
				FUNCT3_MEM_HU:
					ctrl.mem_size = MEM_SIZE_HALF;
				default:
					ctrl.mem_size = MEM_SIZE_WORD;
				endcase
			end
			OPCODE_OP_IMM, OPCODE_OP: begin
				dec_regfile_we = 1'b1;
				if (ir_i.r.opcode == OPCODE_OP_IMM)
					ctrl.alu_in2_sel = ALU_IN2_SEL_I_IMM;
				unique case (funct3_op_t'(ir_i.r.funct3))
				FUNCT3_OP_ADD_SUB:
					// no subtract form among the immediates.
					if (ir_i.r.opcode == OPCODE_OP && ir_i.r.funct7[5])
						ctrl.alu_op = ALU_OP_SUB;
					else
						ctrl.alu_op = ALU_OP_ADD;
				FUNCT3_OP_SLL:
					ctrl.alu_op = ALU_OP_SLL;
				FUNCT3_OP_SLT:
					ctrl.alu_op = ALU_OP_SLT;
				FUNCT3_OP_SLTU:
					ctrl.alu_op = ALU_OP_SLTU;
				FUNCT3_OP_XOR:
					ctrl.alu_op = ALU_OP_XOR;
				FUNCT3_OP_SR:
					if (ir_i.r.funct7[5])
						ctrl.alu_op = ALU_OP_SRA;
					else
						ctrl.alu_op = ALU_OP_SRL;
				FUNCT3_OP_OR:
					ctrl.alu_op = ALU_OP_OR;
				FUNCT3_OP_AND:
					ctrl.alu_op = ALU_OP_AND;
				endcase
			end
			OPCODE_MISC_MEM: begin
				// fence and fence.i have nothing to order.
			end
			default: begin
			end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		unique case (state)
		RESET:
			next_state = FETCH;
		FETCH:
			next_state = EXECUTE;
		EXECUTE:
			next_state = misaligned_i ? ERROR : FETCH;
		ERROR:
			next_state = ERROR;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= RESET;
		end else begin
			state <= next_state;
		end
	end
endmodule

// ==== source/rv_fetch_unit.sv ====
`include "rv_macros.svh"

module rv_fetch_unit (
	input logic clk_i,
	input logic reset_i,
	rv_ctrl_if.datapath ctrl,
	input logic [`RV_XLEN-1:0] rd_data_i,
	input logic [`RV_XLEN-1:0] alu_out_i,
	input logic branch_taken_i,
	output logic [`RV_XLEN-1:0] pc_o,
	output logic [`RV_XLEN-1:0] pc_plus4_o,
	output rv_pkg::instruction_t ir_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] next_pc;

	assign pc_plus4_o = pc_o + `RV_XLEN'd4;

	always_comb begin
		unique case (ctrl.next_pc_sel)
		NEXT_PC_SEL_ALU_OUT:
			// jalr clears the low bit of its target.
			next_pc = {alu_out_i[`RV_XLEN-1:1], 1'b0};
		NEXT_PC_SEL_COMPARE_OUT:
			next_pc = branch_taken_i ? alu_out_i : pc_plus4_o;
		default:
			next_pc = pc_plus4_o;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_o <= '0;
		end else if (ctrl.pc_we) begin
			pc_o <= next_pc;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ctrl.ir_we) begin
			ir_o <= rd_data_i;
		end
	end
endmodule

// ==== source/rv_regfile.sv ====
`include "rv_macros.svh"

module rv_regfile (
	input logic clk_i,
	input logic reset_i,
	rv_ctrl_if.datapath ctrl,
	input rv_pkg::instruction_t ir_i,
	input logic [`RV_XLEN-1:0] pc_plus4_i,
	input logic [`RV_XLEN-1:0] alu_out_i,
	input logic [`RV_XLEN-1:0] mem_rd_data_i,
	output logic [`RV_XLEN-1:0] rs1_data_o,
	output logic [`RV_XLEN-1:0] rs2_data_o,
	output logic [4:0] retire_rd_o,
	output logic [`RV_XLEN-1:0] retire_value_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];
	logic [`RV_XLEN-1:0] wr_data;
	logic wr_en;

	// x0 reads as zero and is never written.
	assign rs1_data_o = (ir_i.r.rs1 == 5'd0) ? '0 : regs[ir_i.r.rs1];
	assign rs2_data_o = (ir_i.r.rs2 == 5'd0) ? '0 : regs[ir_i.r.rs2];

	always_comb begin
		unique case (ctrl.regfile_in_sel)
		REGFILE_IN_SEL_PC_4:
			wr_data = pc_plus4_i;
		REGFILE_IN_SEL_MEM_RD:
			wr_data = mem_rd_data_i;
		default:
			wr_data = alu_out_i;
		endcase
	end

	assign wr_en = ctrl.regfile_we && (ir_i.r.rd != 5'd0);

	// trace shows the write that actually happens.
	assign retire_rd_o = wr_en ? ir_i.r.rd : 5'd0;
	assign retire_value_o = wr_en ? wr_data : '0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[ir_i.r.rd] <= wr_data;
		end
	end
endmodule

// ==== source/rv_exec_unit.sv ====
`include "rv_macros.svh"

module rv_exec_unit (
	rv_ctrl_if.datapath ctrl,
	input rv_pkg::instruction_t ir_i,
	input logic [`RV_XLEN-1:0] pc_i,
	input logic [`RV_XLEN-1:0] rs1_data_i,
	input logic [`RV_XLEN-1:0] rs2_data_i,
	output logic [`RV_XLEN-1:0] alu_out_o,
	output logic branch_taken_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] in1;
	logic [`RV_XLEN-1:0] in2;
	logic [4:0] shamt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign in1 = (ctrl.alu_in1_sel == ALU_IN1_SEL_PC) ? pc_i : rs1_data_i;

	always_comb begin
		unique case (ctrl.alu_in2_sel)
		ALU_IN2_SEL_U_IMM:
			in2 = {ir_i.u.imm, 12'b0};
		ALU_IN2_SEL_J_IMM:
			in2 = {{11{ir_i.j.imm20}}, ir_i.j.imm20, ir_i.j.imm19_12,
				ir_i.j.imm11, ir_i.j.imm10_1, 1'b0};
		ALU_IN2_SEL_I_IMM:
			in2 = {{20{ir_i.i.imm[11]}}, ir_i.i.imm};
		ALU_IN2_SEL_B_IMM:
			in2 = {{19{ir_i.b.imm12}}, ir_i.b.imm12, ir_i.b.imm11,
				ir_i.b.imm10_5, ir_i.b.imm4_1, 1'b0};
		ALU_IN2_SEL_S_IMM:
			in2 = {{20{ir_i.s.imm_hi[6]}}, ir_i.s.imm_hi, ir_i.s.imm_lo};
		default:
			in2 = rs2_data_i;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu and compare unit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign shamt = in2[4:0];

	always_comb begin
		unique case (ctrl.alu_op)
		ALU_OP_SUB:
			alu_out_o = in1 - in2;
		ALU_OP_SLL:
			alu_out_o = in1 << shamt;
		ALU_OP_SLT:
			alu_out_o = {31'b0, $signed(in1) < $signed(in2)};
		ALU_OP_SLTU:
			alu_out_o = {31'b0, in1 < in2};
		ALU_OP_XOR:
			alu_out_o = in1 ^ in2;
		ALU_OP_SRL:
			alu_out_o = in1 >> shamt;
		ALU_OP_SRA:
			alu_out_o = $signed(in1) >>> shamt;
		ALU_OP_OR:
			alu_out_o = in1 | in2;
		ALU_OP_AND:
			alu_out_o = in1 & in2;
		ALU_OP_IN2_PASSTHROUGH:
			alu_out_o = in2;
		default:
			alu_out_o = in1 + in2;
		endcase
	end

	// compares the registers, never the alu operands.
	always_comb begin
		unique case (ctrl.compare_op)
		COMPARE_OP_NE:
			branch_taken_o = rs1_data_i != rs2_data_i;
		COMPARE_OP_LT:
			branch_taken_o = $signed(rs1_data_i) < $signed(rs2_data_i);
		COMPARE_OP_GE:
			branch_taken_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
		COMPARE_OP_LTU:
			branch_taken_o = rs1_data_i < rs2_data_i;
		COMPARE_OP_GEU:
			branch_taken_o = rs1_data_i >= rs2_data_i;
		default:
			branch_taken_o = rs1_data_i == rs2_data_i;
		endcase
	end
endmodule

// ==== source/rv_data_memory.sv ====
`include "rv_macros.svh"

module rv_data_memory (
	input logic clk_i,
	rv_ctrl_if.datapath ctrl,
	input logic [`RV_XLEN-1:0] pc_i,
	input logic [`RV_XLEN-1:0] alu_out_i,
	input logic [`RV_XLEN-1:0] rs2_data_i,
	input logic load_we_i,
	input logic [`RV_MEM_AW-1:0] load_addr_i,
	input logic [`RV_XLEN-1:0] load_data_i,
	output logic [`RV_XLEN-1:0] rd_data_o,
	output logic misaligned_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];
	logic [`RV_XLEN-1:0] addr;
	logic [`RV_MEM_AW-1:0] word_idx;
	logic [1:0] byte_off;
	logic [`RV_XLEN-1:0] rd_word;
	logic [7:0] rd_byte;
	logic [15:0] rd_half;
	logic [`RV_XLEN-1:0] wr_data;
	logic [3:0] wr_mask;

	// instruction fetch unless a load or store is decoded.
	assign addr = ctrl.mem_addr_from_alu ? alu_out_i : pc_i;
	assign word_idx = addr[`RV_MEM_AW+1:2];
	assign byte_off = addr[1:0];

	assign misaligned_o = ctrl.mem_addr_from_alu &&
		((ctrl.mem_size == MEM_SIZE_HALF && byte_off[0]) ||
		(ctrl.mem_size == MEM_SIZE_WORD && byte_off != 2'b00));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rd_word = mem[word_idx];
	assign rd_byte = rd_word[{byte_off, 3'b000} +: 8];
	assign rd_half = rd_word[{byte_off[1], 4'b0000} +: 16];

	always_comb begin
		unique case (ctrl.mem_size)
		MEM_SIZE_BYTE:
			rd_data_o = {{24{ctrl.mem_signed & rd_byte[7]}}, rd_byte};
		MEM_SIZE_HALF:
			rd_data_o = {{16{ctrl.mem_signed & rd_half[15]}}, rd_half};
		default:
			rd_data_o = rd_word;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// replicate the store data into every lane.
	always_comb begin
		unique case (ctrl.mem_size)
		MEM_SIZE_BYTE: begin
			wr_data = {4{rs2_data_i[7:0]}};
			wr_mask = 4'b0001 << byte_off;
		end
		MEM_SIZE_HALF: begin
			wr_data = {2{rs2_data_i[15:0]}};
			wr_mask = byte_off[1] ? 4'b1100 : 4'b0011;
		end
		default: begin
			wr_data = rs2_data_i;
			wr_mask = 4'b1111;
		end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (load_we_i) begin
			mem[load_addr_i] <= load_data_i;
		end else if (ctrl.mem_wr_en) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_mask[i]) begin
					mem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
				end
			end
		end
	end
endmodule

// ==== source/rv_core.sv ====
`include "rv_macros.svh"

module rv_core (
	input logic clk_i,
	input logic reset_i,
	input logic load_we_i,
	input logic [`RV_MEM_AW-1:0] load_addr_i,
	input logic [`RV_XLEN-1:0] load_data_i,
	output logic retire_valid_o,
	output logic [`RV_XLEN-1:0] retire_pc_o,
	output logic [4:0] retire_rd_o,
	output logic [`RV_XLEN-1:0] retire_value_o,
	output logic halted_o
);
	import rv_pkg::*;

	instruction_t ir;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] alu_out;
	logic [`RV_XLEN-1:0] mem_rd_data;
	logic branch_taken;
	logic misaligned;

	rv_ctrl_if ctrl ();

	assign retire_pc_o = pc;

	rv_control u_control (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.misaligned_i(misaligned),
		.ir_i(ir),
		.halted_o(halted_o),
		.retire_valid_o(retire_valid_o),
		.ctrl(ctrl)
	);

	rv_fetch_unit u_fetch (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ctrl(ctrl),
		.rd_data_i(mem_rd_data),
		.alu_out_i(alu_out),
		.branch_taken_i(branch_taken),
		.pc_o(pc),
		.pc_plus4_o(pc_plus4),
		.ir_o(ir)
	);

	rv_regfile u_regfile (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ctrl(ctrl),
		.ir_i(ir),
		.pc_plus4_i(pc_plus4),
		.alu_out_i(alu_out),
		.mem_rd_data_i(mem_rd_data),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data),
		.retire_rd_o(retire_rd_o),
		.retire_value_o(retire_value_o)
	);

	rv_exec_unit u_exec (
		.ctrl(ctrl),
		.ir_i(ir),
		.pc_i(pc),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.alu_out_o(alu_out),
		.branch_taken_o(branch_taken)
	);

	rv_data_memory u_memory (
		.clk_i(clk_i),
		.ctrl(ctrl),
		.pc_i(pc),
		.alu_out_i(alu_out),
		.rs2_data_i(rs2_data),
		.load_we_i(load_we_i),
		.load_addr_i(load_addr_i),
		.load_data_i(load_data_i),
		.rd_data_o(mem_rd_data),
		.misaligned_o(misaligned)
	);
endmodule

// ==== verification/rv_core_properties.sv ====
module rv_core_properties (
	input logic clk_i,
	input logic reset_i,
	input logic [1:0] state_i,
	input logic misaligned_i,
	input logic pc_we_i,
	input logic regfile_we_i,
	input logic mem_wr_en_i
);
	// state codes of the control FSM.
	localparam logic [1:0] st_fetch = 2'd1;
	localparam logic [1:0] st_execute = 2'd2;
	localparam logic [1:0] st_error = 2'd3;

	int assert_failures = 0;

	execute_to_fetch: assert property (@(posedge clk_i)
		(!reset_i && state_i == st_execute && !misaligned_i) |=> (state_i == st_fetch))
		else begin
			assert_failures++;
			$error("state after execute is %0d instead of fetch", state_i);
		end

	strobes_in_execute: assert property (@(posedge clk_i)
		(!reset_i && (pc_we_i || regfile_we_i || mem_wr_en_i)) |-> (state_i == st_execute))
		else begin
			assert_failures++;
			$error("write strobe raised in state %0d", state_i);
		end

	error_is_final: assert property (@(posedge clk_i)
		(!reset_i && state_i == st_error) |=> (state_i == st_error))
		else begin
			assert_failures++;
			$error("error state left without a reset");
		end
endmodule

bind rv_control rv_core_properties u_properties (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.state_i(state),
	.misaligned_i(misaligned_i),
	.pc_we_i(ctrl.pc_we),
	.regfile_we_i(ctrl.regfile_we),
	.mem_wr_en_i(ctrl.mem_wr_en)
);

// ==== verification/rv_core_tb.sv ====
`include "rv_macros.svh"

module rv_core_tb;
	localparam int half_period = 20;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	// addi x31, x0, -1 in slots that must never run.
	localparam logic [31:0] poison = 32'hfff0_0f93;

	logic clk_i;
	logic reset_i;
	logic load_we_i;
	logic [`RV_MEM_AW-1:0] load_addr_i;
	logic [`RV_XLEN-1:0] load_data_i;
	logic retire_valid_o;
	logic [`RV_XLEN-1:0] retire_pc_o;
	logic [4:0] retire_rd_o;
	logic [`RV_XLEN-1:0] retire_value_o;
	logic halted_o;

	logic [`RV_MEM_AW-1:0] image_index [$];
	logic [31:0] image_data [$];
	logic [31:0] row_pc [$];
	logic [4:0] row_rd [$];
	logic [31:0] row_value [$];

	logic [31:0] data_value;
	int cycle;
	int checks;
	int errors;
	bit row_ok;

	rv_core UUT (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.load_we_i(load_we_i),
		.load_addr_i(load_addr_i),
		.load_data_i(load_data_i),
		.retire_valid_o(retire_valid_o),
		.retire_pc_o(retire_pc_o),
		.retire_rd_o(retire_rd_o),
		.retire_value_o(retire_value_o),
		.halted_o(halted_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #half_period clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle <= cycle + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction encoders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic place_word(input logic [31:0] addr, input logic [31:0] word);
		image_index.push_back(addr[`RV_MEM_AW+1:2]);
		image_data.push_back(word);
	endtask

	task automatic add_row(input logic [31:0] pc, input logic [31:0] word,
		input logic [4:0] rd, input logic [31:0] value);
		place_word(pc, word);
		row_pc.push_back(pc);
		row_rd.push_back(rd);
		row_value.push_back(value);
	endtask

	task automatic build_program();
		logic [31:0] d;
		d = data_value;
		add_row(32'h00, u_type(20'h12345, 5'd1, op_lui), 5'd1, 32'h1234_5000);
		add_row(32'h04, u_type(20'h00001, 5'd2, op_auipc), 5'd2, 32'h0000_1004);
		add_row(32'h08, i_type(12'hffb, 5'd0, 3'd0, 5'd3, op_imm), 5'd3, 32'hffff_fffb);
		add_row(32'h0c, i_type(12'h007, 5'd0, 3'd0, 5'd4, op_imm), 5'd4, 32'h0000_0007);
		add_row(32'h10, r_type(7'h20, 5'd3, 5'd4, 3'd0, 5'd5), 5'd5, 32'h0000_000c);
		add_row(32'h14, r_type(7'h00, 5'd4, 5'd3, 3'd2, 5'd6), 5'd6, 32'h0000_0001);
		add_row(32'h18, r_type(7'h00, 5'd4, 5'd3, 3'd3, 5'd7), 5'd7, 32'h0000_0000);
		add_row(32'h1c, i_type(12'h004, 5'd4, 3'd1, 5'd8, op_imm), 5'd8, 32'h0000_0070);
		add_row(32'h20, i_type(12'h401, 5'd3, 3'd5, 5'd9, op_imm), 5'd9, 32'hffff_fffd);
		add_row(32'h24, r_type(7'h00, 5'd4, 5'd3, 3'd5, 5'd10), 5'd10, 32'h01ff_ffff);
		add_row(32'h28, i_type(12'h0f0, 5'd4, 3'd4, 5'd11, op_imm), 5'd11, 32'h0000_00f7);
		add_row(32'h2c, r_type(7'h00, 5'd4, 5'd1, 3'd6, 5'd12), 5'd12, 32'h1234_5007);
		add_row(32'h30, r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd13), 5'd13, 32'h0000_1000);
		add_row(32'h34, i_type(12'h001, 5'd4, 3'd0, 5'd0, op_imm), 5'd0, 32'h0);

		// loads from the random word at 0x200, stores into 0x300.
		add_row(32'h38, i_type(12'h200, 5'd0, 3'd0, 5'd14, op_imm), 5'd14, 32'h0000_0200);
		add_row(32'h3c, i_type(12'h000, 5'd14, 3'd2, 5'd15, op_load), 5'd15, d);
		add_row(32'h40, i_type(12'h001, 5'd14, 3'd0, 5'd16, op_load), 5'd16,
			{{24{d[15]}}, d[15:8]});
		add_row(32'h44, i_type(12'h003, 5'd14, 3'd4, 5'd17, op_load), 5'd17,
			{24'h0, d[31:24]});
		add_row(32'h48, i_type(12'h002, 5'd14, 3'd1, 5'd18, op_load), 5'd18,
			{{16{d[31]}}, d[31:16]});
		add_row(32'h4c, i_type(12'h000, 5'd14, 3'd5, 5'd19, op_load), 5'd19,
			{16'h0, d[15:0]});
		add_row(32'h50, s_type(12'h100, 5'd15, 5'd14, 3'd2), 5'd0, 32'h0);
		add_row(32'h54, s_type(12'h101, 5'd4, 5'd14, 3'd0), 5'd0, 32'h0);
		add_row(32'h58, s_type(12'h102, 5'd3, 5'd14, 3'd1), 5'd0, 32'h0);
		add_row(32'h5c, i_type(12'h100, 5'd14, 3'd2, 5'd20, op_load), 5'd20,
			{16'hfffb, 8'h07, d[7:0]});
		add_row(32'h60, i_type(12'h102, 5'd14, 3'd0, 5'd21, op_load), 5'd21, 32'hffff_fffb);
		add_row(32'h64, i_type(12'h102, 5'd14, 3'd5, 5'd22, op_load), 5'd22, 32'h0000_fffb);

		// x3 = -5, x4 = 7, x6 = 1, x7 = 0.
		add_row(32'h68, b_type(13'd8, 5'd6, 5'd6, 3'd0), 5'd0, 32'h0);
		place_word(32'h6c, poison);
		add_row(32'h70, b_type(13'd8, 5'd6, 5'd6, 3'd1), 5'd0, 32'h0);
		add_row(32'h74, b_type(13'd8, 5'd4, 5'd3, 3'd4), 5'd0, 32'h0);
		place_word(32'h78, poison);
		add_row(32'h7c, b_type(13'd8, 5'd4, 5'd3, 3'd5), 5'd0, 32'h0);
		add_row(32'h80, b_type(13'd8, 5'd4, 5'd3, 3'd6), 5'd0, 32'h0);
		add_row(32'h84, b_type(13'd8, 5'd4, 5'd3, 3'd7), 5'd0, 32'h0);
		place_word(32'h88, poison);
		add_row(32'h8c, b_type(13'd8, 5'd7, 5'd6, 3'd1), 5'd0, 32'h0);
		place_word(32'h90, poison);
		add_row(32'h94, b_type(13'd8, 5'd7, 5'd6, 3'd0), 5'd0, 32'h0);
		add_row(32'h98, b_type(13'd8, 5'd3, 5'd4, 3'd5), 5'd0, 32'h0);
		place_word(32'h9c, poison);
		add_row(32'ha0, b_type(13'd8, 5'd3, 5'd4, 3'd4), 5'd0, 32'h0);
		add_row(32'ha4, b_type(13'd8, 5'd3, 5'd4, 3'd6), 5'd0, 32'h0);
		place_word(32'ha8, poison);
		add_row(32'hac, b_type(13'd8, 5'd3, 5'd4, 3'd7), 5'd0, 32'h0);

		// jalr target 0xb4 + 21 has bit 0 set.
		add_row(32'hb0, j_type(21'd12, 5'd23), 5'd23, 32'h0000_00b4);
		place_word(32'hb4, poison);
		place_word(32'hb8, poison);
		add_row(32'hbc, i_type(12'd21, 5'd23, 3'd0, 5'd25, op_jalr), 5'd25, 32'h0000_00c0);
		place_word(32'hc0, poison);
		place_word(32'hc4, poison);
		add_row(32'hc8, i_type(12'h001, 5'd25, 3'd0, 5'd26, op_imm), 5'd26, 32'h0000_00c1);
		add_row(32'hcc, 32'h0ff0_000f, 5'd0, 32'h0);

		// misaligned word load halts the core.
		place_word(32'hd0, i_type(12'h002, 5'd14, 3'd2, 5'd27, op_load));
		place_word(32'hd4, poison);
		place_word(32'h200, d);
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("error at %0t: %s = %h, expected %h", $time, name, got, expected);
			errors++;
			row_ok = 1'b0;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		@(negedge reset_i);
		repeat (row_pc.size() * 2 + 20) @(posedge clk_i);
		$display("timeout: the program did not finish within %0d cycles",
			row_pc.size() * 2 + 20);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int last_cycle;
		int halt_wait;
		reset_i = 1'b1;
		load_we_i = 1'b0;
		load_addr_i = '0;
		load_data_i = '0;
		checks = 0;
		errors = 0;
		void'($urandom(32'h5810_c6a5));
		// top bits set so that sign and zero extension differ.
		data_value = $urandom() | 32'h8000_8000;
		build_program();

		for (int i = 0; i < image_data.size(); i++) begin
			@(posedge clk_i);
			load_we_i <= 1'b1;
			load_addr_i <= image_index[i];
			load_data_i <= image_data[i];
		end
		@(posedge clk_i);
		load_we_i <= 1'b0;
		repeat (3) @(posedge clk_i);
		reset_i <= 1'b0;

		@(negedge clk_i);
		row_ok = 1'b1;
		compare_word("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
		compare_word("halted_o", {31'b0, halted_o}, 32'd0);
		$display("state after reset: %s", row_ok ? "ok" : "mismatch");

		// the first instruction commits on the third edge after release.
		last_cycle = cycle;
		for (int r = 0; r < row_pc.size(); r++) begin
			@(negedge clk_i);
			while (!retire_valid_o) @(negedge clk_i);
			row_ok = 1'b1;
			compare_word("retire_pc_o", retire_pc_o, row_pc[r]);
			compare_word("retire_rd_o", {27'b0, retire_rd_o}, {27'b0, row_rd[r]});
			compare_word("retire_value_o", retire_value_o, row_value[r]);
			compare_word("retire_valid_o spacing", cycle - last_cycle, 32'd2);
			last_cycle = cycle;
			$display("row %0d pc %h rd %0d: %s", r, row_pc[r], row_rd[r],
				row_ok ? "ok" : "mismatch");
		end

		row_ok = 1'b1;
		halt_wait = 0;
		while (!halted_o && halt_wait < 8) begin
			@(negedge clk_i);
			halt_wait++;
			compare_word("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
			compare_word("retire_rd_o", {27'b0, retire_rd_o}, 32'd0);
		end
		compare_word("halted_o", {31'b0, halted_o}, 32'd1);
		repeat (8) begin
			@(negedge clk_i);
			compare_word("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
			compare_word("retire_rd_o", {27'b0, retire_rd_o}, 32'd0);
			compare_word("halted_o", {31'b0, halted_o}, 32'd1);
		end
		$display("halt on misaligned load: %s", row_ok ? "ok" : "mismatch");

		errors += UUT.u_control.u_properties.assert_failures;
		$display("%0d rows, %0d checks, %0d errors", row_pc.size(), checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end
endmodule

// ==== flist.f ====
+incdir+include
source/rv_pkg.sv
source/rv_ctrl_if.sv
source/rv_control.sv
source/rv_fetch_unit.sv
source/rv_regfile.sv
source/rv_exec_unit.sv
source/rv_data_memory.sv
source/rv_core.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f flist.f \
	&& ./obj_dir/Vrv_core_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
